//--- Bender.yml
package:
  name: div64

sources:
  - logic/div_pkg.sv
  - logic/cla_pkg.sv
  - logic/cla_4.sv
  - logic/cla_64.sv
  - logic/div_operand_prep.sv
  - logic/div_iter.sv
  - logic/div_result_fix.sv
  - logic/div_top.sv
  - target: simulation
    files:
      - tb/div_tb.sv

//--- flist.f
logic/div_pkg.sv
logic/cla_pkg.sv
logic/cla_4.sv
logic/cla_64.sv
logic/div_operand_prep.sv
logic/div_iter.sv
logic/div_result_fix.sv
logic/div_top.sv
tb/div_tb.sv

//--- logic/cla_4.sv
`timescale 1ns/1ns

module cla_4 (
  input  logic [cla_pkg::cla_blk_w-1:0] a,
  input  logic [cla_pkg::cla_blk_w-1:0] b,
  input  logic                          cin,
  output logic [cla_pkg::cla_blk_w-1:0] sum,
  output logic                          grp_p,
  output logic                          grp_g
);

  logic [cla_pkg::cla_blk_w-1:0] p;
  logic [cla_pkg::cla_blk_w-1:0] g;
  logic [cla_pkg::cla_blk_w-1:0] c;

  // xor propagate so the sum reuses it
  assign p = a ^ b;
  assign g = a & b;

  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

  // block terms for the next lookahead level
  assign grp_p = &p;
  assign grp_g = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
               | (p[3] & p[2] & p[1] & g[0]);

endmodule

//--- logic/cla_64.sv
`timescale 1ns/1ns

module cla_64 (
  input  logic [cla_pkg::cla_blocks*cla_pkg::cla_blk_w-1:0] a,
  input  logic [cla_pkg::cla_blocks*cla_pkg::cla_blk_w-1:0] b,
  input  logic                                              cin,
  output logic [cla_pkg::cla_blocks*cla_pkg::cla_blk_w-1:0] sum,
  output logic                                              cout
);

  // carries into cells 1..3 plus the generate of all four cells
  function automatic logic [3:0] lookahead(
    input logic [3:0] p,
    input logic [3:0] g,
    input logic       c0
  );
    logic [3:0] r;
    r[0] = g[0] | (p[0] & c0);
    r[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0);
    r[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c0);
    r[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    return r;
  endfunction

  logic [cla_pkg::cla_blocks-1:0] blk_p;
  logic [cla_pkg::cla_blocks-1:0] blk_g;
  logic [cla_pkg::cla_blocks-1:0] blk_c;
  logic [cla_pkg::cla_groups-1:0] grp_p;
  logic [cla_pkg::cla_groups-1:0] grp_g;
  logic [cla_pkg::cla_groups-1:0] grp_c;
  logic [3:0]                     top_la;

  // second level over the four groups
  assign top_la = lookahead(grp_p, grp_g, cin);
  assign grp_c  = {top_la[2:0], cin};
  assign cout   = top_la[3] | (&grp_p & cin);

  genvar gi;
  genvar bi;
  generate
    for (gi = 0; gi < cla_pkg::cla_groups; gi++) begin : g_grp
      localparam int base = gi * (cla_pkg::cla_blocks / cla_pkg::cla_groups);
      logic [3:0] grp_la;

      assign grp_la = lookahead(blk_p[base +: 4], blk_g[base +: 4], grp_c[gi]);
      assign blk_c[base +: 4] = {grp_la[2:0], grp_c[gi]};
      assign grp_p[gi] = &blk_p[base +: 4];
      assign grp_g[gi] = grp_la[3];
    end

    for (bi = 0; bi < cla_pkg::cla_blocks; bi++) begin : g_blk
      cla_4 u_cla_4 (
        .a     (a[bi*cla_pkg::cla_blk_w +: cla_pkg::cla_blk_w]),
        .b     (b[bi*cla_pkg::cla_blk_w +: cla_pkg::cla_blk_w]),
        .cin   (blk_c[bi]),
        .sum   (sum[bi*cla_pkg::cla_blk_w +: cla_pkg::cla_blk_w]),
        .grp_p (blk_p[bi]),
        .grp_g (blk_g[bi])
      );
    end
  endgenerate

  always_comb begin
    if (!$isunknown({a, b, cin})) begin
      assert #0 ({cout, sum} == {1'b0, a} + {1'b0, b} + cin)
        else $error("cla_64: sum/cout differ from a + b + cin");
    end
  end

endmodule

//--- logic/cla_pkg.sv
package cla_pkg;

  // bits per first-level lookahead block
  localparam int cla_blk_w = 4;

  // sixteen blocks make the 64-bit adder
  localparam int cla_blocks = 16;

  // second level looks ahead over groups of four blocks
  localparam int cla_groups = 4;

endpackage

//--- logic/div_iter.sv
`timescale 1ns/1ns

module div_iter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      div_valid,
  input  logic                      flush,
  input  logic [div_pkg::xlen-1:0]  dividend_mag,
  input  logic [div_pkg::xlen-1:0]  divisor_pos,
  input  logic [div_pkg::xlen-1:0]  divisor_neg,
  output logic                      busy,
  output logic [div_pkg::xlen-1:0]  quotient_raw,
  output logic [div_pkg::xlen:0]    remainder_raw
);

  // upper half partial remainder, lower half dividend bits then quotient
  logic [2*div_pkg::xlen-1:0] work;
  // bit 64 of the partial remainder
  logic                       rem_sign;
  logic [div_pkg::cnt_w-1:0]  cnt;

  logic                       first_step;
  logic                       last_step;
  logic [2*div_pkg::xlen-1:0] work_cur;
  logic                       sign_cur;
  logic                       subtract;
  logic [div_pkg::xlen-1:0]   addend;
  logic [div_pkg::xlen-1:0]   step_sum;
  logic                       step_cout;
  logic                       new_sign;
  logic                       q_bit;

  // operands land in prep on the start edge, so step one reads them directly
  assign first_step = busy && (cnt == '0);
  assign last_step  = (cnt == (div_pkg::div_steps - 1));
  assign work_cur   = first_step ? {{div_pkg::xlen{1'b0}}, dividend_mag} : work;
  assign sign_cur   = first_step ? 1'b0 : rem_sign;

  // non-negative remainder subtracts, negative adds back
  assign subtract = ~sign_cur;
  assign addend   = subtract ? divisor_neg : divisor_pos;

  // shifted remainder with the next dividend bit in the lsb
  cla_64 u_cla_64 (
    .a    (work_cur[2*div_pkg::xlen-2 -: div_pkg::xlen]),
    .b    (addend),
    .cin  (1'b0),
    .sum  (step_sum),
    .cout (step_cout)
  );

  // sign bit of the 65-bit result
  // minus divisor sign-extends with ones unless the divisor is zero
  assign new_sign = work_cur[2*div_pkg::xlen-1] ^ (subtract & |divisor_pos) ^ step_cout;
  assign q_bit    = ~new_sign;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (div_valid) begin
      // also restarts a running operation
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy) begin
      if (last_step) begin
        busy <= 1'b0;
        cnt  <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      work     <= '0;
      rem_sign <= 1'b0;
    end else if (busy) begin
      work     <= {step_sum, work_cur[div_pkg::xlen-2:0], q_bit};
      rem_sign <= new_sign;
    end
  end

  assign quotient_raw  = work[div_pkg::xlen-1:0];
  assign remainder_raw = {rem_sign, work[2*div_pkg::xlen-1:div_pkg::xlen]};

  a_flush_stops: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy)
    else $error("div_iter: busy still set after flush");

  a_cnt_busy: assert property (@(posedge clk) disable iff (!rst_n) (cnt != '0) |-> busy)
    else $error("div_iter: counter running while idle");

endmodule

//--- logic/div_operand_prep.sv
`timescale 1ns/1ns

module div_operand_prep (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [div_pkg::xlen-1:0]  dividend,
  input  logic [div_pkg::xlen-1:0]  divisor,
  input  logic [div_pkg::op_w-1:0]  div_type,
  input  logic                      div_valid,
  output logic [div_pkg::xlen-1:0]  dividend_mag,
  output logic [div_pkg::xlen-1:0]  divisor_pos,
  output logic [div_pkg::xlen-1:0]  divisor_neg,
  output logic                      dividend_sign,
  output logic                      divisor_sign,
  output logic                      div_zero,
  output logic [div_pkg::op_w-1:0]  op_r
);

  logic                     is_signed;
  logic                     dvd_neg;
  logic                     dvs_neg;
  logic [div_pkg::xlen-1:0] dividend_2c;
  logic [div_pkg::xlen-1:0] divisor_2c;

  assign is_signed   = ~div_type[div_pkg::op_unsigned_bit];
  assign dvd_neg     = is_signed & dividend[div_pkg::xlen-1];
  assign dvs_neg     = is_signed & divisor[div_pkg::xlen-1];
  assign dividend_2c = ~dividend + 1'b1;
  assign divisor_2c  = ~divisor + 1'b1;

  // held until the next start so an idle result stays put
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dividend_mag  <= '0;
      divisor_pos   <= '0;
      divisor_neg   <= '0;
      dividend_sign <= 1'b0;
      divisor_sign  <= 1'b0;
      div_zero      <= 1'b0;
      op_r          <= '0;
    end else if (div_valid) begin
      dividend_mag  <= dvd_neg ? dividend_2c : dividend;
      // a negative divisor swaps the roles of the raw value and its negation
      divisor_pos   <= dvs_neg ? divisor_2c : divisor;
      divisor_neg   <= dvs_neg ? divisor : divisor_2c;
      dividend_sign <= dvd_neg;
      divisor_sign  <= dvs_neg;
      div_zero      <= (divisor == '0);
      op_r          <= div_type;
    end
  end

endmodule

//--- logic/div_pkg.sv
package div_pkg;

  // operand and result width
  localparam int xlen = 64;

  // one quotient bit per iteration
  localparam int div_steps = 64;

  // counts 0 .. div_steps-1
  localparam int cnt_w = 6;

  localparam int op_w = 2;

  // bit 0 set means unsigned
  // bit 1 set means the remainder is returned
  localparam logic [op_w-1:0] op_div  = 2'b00;
  localparam logic [op_w-1:0] op_divu = 2'b01;
  localparam logic [op_w-1:0] op_rem  = 2'b10;
  localparam logic [op_w-1:0] op_remu = 2'b11;

  localparam int op_unsigned_bit = 0;
  localparam int op_rem_bit      = 1;

endpackage

//--- logic/div_result_fix.sv
`timescale 1ns/1ns

module div_result_fix (
  input  logic [div_pkg::xlen-1:0]  quotient_raw,
  input  logic [div_pkg::xlen:0]    remainder_raw,
  input  logic [div_pkg::xlen-1:0]  divisor_pos,
  input  logic                      dividend_sign,
  input  logic                      divisor_sign,
  input  logic                      div_zero,
  input  logic [div_pkg::op_w-1:0]  op_r,
  output logic [div_pkg::xlen-1:0]  result
);

  logic [div_pkg::xlen-1:0] rem_fixed;
  logic [div_pkg::xlen-1:0] quot_signed;
  logic [div_pkg::xlen-1:0] rem_signed;
  logic [div_pkg::xlen-1:0] quot_out;

  // last step may leave the remainder negative
  assign rem_fixed = remainder_raw[div_pkg::xlen] ?
                     remainder_raw[div_pkg::xlen-1:0] + divisor_pos :
                     remainder_raw[div_pkg::xlen-1:0];

  assign quot_signed = (dividend_sign ^ divisor_sign) ? ~quotient_raw + 1'b1 : quotient_raw;

  // truncating division, remainder follows the dividend
  assign rem_signed = dividend_sign ? ~rem_fixed + 1'b1 : rem_fixed;

  // with a zero divisor the iteration never goes negative and leaves the
  // dividend magnitude as remainder, so rem_signed is already the dividend
  assign quot_out = div_zero ? {div_pkg::xlen{1'b1}} : quot_signed;

  assign result = op_r[div_pkg::op_rem_bit] ? rem_signed : quot_out;

endmodule

//--- logic/div_top.sv
`timescale 1ns/1ns

module div_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [div_pkg::xlen-1:0]  dividend,
  input  logic [div_pkg::xlen-1:0]  divisor,
  input  logic [div_pkg::op_w-1:0]  div_type,
  input  logic                      div_valid,
  input  logic                      flush,
  output logic                      out_valid,
  output logic [div_pkg::xlen-1:0]  result
);

  logic [div_pkg::xlen-1:0] dividend_mag;
  logic [div_pkg::xlen-1:0] divisor_pos;
  logic [div_pkg::xlen-1:0] divisor_neg;
  logic                     dividend_sign;
  logic                     divisor_sign;
  logic                     div_zero;
  logic [div_pkg::op_w-1:0] op_r;
  logic                     busy;
  logic [div_pkg::xlen-1:0] quotient_raw;
  logic [div_pkg::xlen:0]   remainder_raw;

  div_operand_prep u_prep (
    .clk           (clk),
    .rst_n         (rst_n),
    .dividend      (dividend),
    .divisor       (divisor),
    .div_type      (div_type),
    .div_valid     (div_valid),
    .dividend_mag  (dividend_mag),
    .divisor_pos   (divisor_pos),
    .divisor_neg   (divisor_neg),
    .dividend_sign (dividend_sign),
    .divisor_sign  (divisor_sign),
    .div_zero      (div_zero),
    .op_r          (op_r)
  );

  div_iter u_iter (
    .clk           (clk),
    .rst_n         (rst_n),
    .div_valid     (div_valid),
    .flush         (flush),
    .dividend_mag  (dividend_mag),
    .divisor_pos   (divisor_pos),
    .divisor_neg   (divisor_neg),
    .busy          (busy),
    .quotient_raw  (quotient_raw),
    .remainder_raw (remainder_raw)
  );

  div_result_fix u_fix (
    .quotient_raw  (quotient_raw),
    .remainder_raw (remainder_raw),
    .divisor_pos   (divisor_pos),
    .dividend_sign (dividend_sign),
    .divisor_sign  (divisor_sign),
    .div_zero      (div_zero),
    .op_r          (op_r),
    .result        (result)
  );

  // a new request hides the previous result at once
  assign out_valid = ~(busy | div_valid);

endmodule

//--- tb/div_tb.sv
`timescale 1ns/1ns

module div_tb;

  // rough upper bound on requests, used to size the watchdog
  localparam int planned_ops = 48;

  logic                     clk;
  logic                     rst_n;
  logic [div_pkg::xlen-1:0] dividend;
  logic [div_pkg::xlen-1:0] divisor;
  logic [div_pkg::op_w-1:0] div_type;
  logic                     div_valid;
  logic                     flush;
  logic                     out_valid;
  logic [div_pkg::xlen-1:0] result;

  integer                   seed;
  int                       tests;
  int                       fails;
  bit                       pending;
  bit                       cur_bad;
  string                    cur_name;
  logic [div_pkg::xlen-1:0] cur_exp;

  div_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_type  (div_type),
    .div_valid (div_valid),
    .flush     (flush),
    .out_valid (out_valid),
    .result    (result)
  );

  always #4 clk = ~clk;

  // truncating division on magnitudes, signs applied afterwards
  function automatic logic [63:0] expected_result(input logic [63:0] a, input logic [63:0] b,
                                                   input logic [1:0] t);
    logic        a_neg;
    logic        b_neg;
    logic [63:0] am;
    logic [63:0] bm;
    logic [63:0] q;
    logic [63:0] r;
    a_neg = ~t[div_pkg::op_unsigned_bit] & a[63];
    b_neg = ~t[div_pkg::op_unsigned_bit] & b[63];
    am = a_neg ? -a : a;
    bm = b_neg ? -b : b;
    if (b == 64'd0) begin
      q = '1;
      r = a;
    end else begin
      q = am / bm;
      r = am % bm;
      if (a_neg ^ b_neg) q = -q;
      if (a_neg) r = -r;
    end
    return t[div_pkg::op_rem_bit] ? r : q;
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic finish_test(input string name, input bit bad);
    tests++;
    if (bad) fails++;
    $display("%-14s %s", name, bad ? "failed" : "ok");
  endtask

  task automatic run_request(input string name, input logic [63:0] a, input logic [63:0] b,
                             input logic [1:0] t);
    @(posedge clk);
    cur_name  = name;
    cur_exp   = expected_result(a, b, t);
    cur_bad   = 1'b0;
    dividend  <= a;
    divisor   <= b;
    div_type  <= t;
    div_valid <= 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("ERR %s out_valid in request cycle expected 0 actual %b", name, out_valid);
      cur_bad = 1'b1;
    end
    @(posedge clk);
    div_valid <= 1'b0;
    pending = 1'b1;
    wait (pending == 1'b0);
  endtask

  // abort about a third of the way through
  task automatic flush_request(input logic [63:0] a, input logic [63:0] b);
    bit bad;
    bad = 1'b0;
    @(posedge clk);
    dividend  <= a;
    divisor   <= b;
    div_type  <= div_pkg::op_divu;
    div_valid <= 1'b1;
    @(posedge clk);
    div_valid <= 1'b0;
    repeat (20) @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("ERR flush out_valid before flush edge expected 0 actual %b", out_valid);
      bad = 1'b1;
    end
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b1) begin
      $display("ERR flush out_valid after flush edge expected 1 actual %b", out_valid);
      bad = 1'b1;
    end
    finish_test("flush", bad);
  endtask

  initial begin : compare
    int lows;
    forever begin
      @(negedge clk);
      if (pending) begin
        lows = 0;
        while (out_valid !== 1'b1 && lows < 200) begin
          lows++;
          @(negedge clk);
        end
        if (out_valid !== 1'b1) begin
          $display("%s: out_valid did not come back after the request", cur_name);
          cur_bad = 1'b1;
        end else begin
          if (lows != div_pkg::div_steps) begin
            $display("ERR %s latency expected %0d actual %0d", cur_name, div_pkg::div_steps,
                     lows);
            cur_bad = 1'b1;
          end
          if (result !== cur_exp) begin
            $display("ERR %s expected %h actual %h", cur_name, cur_exp, result);
            cur_bad = 1'b1;
          end
        end
        finish_test(cur_name, cur_bad);
        pending = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [63:0] a;
    logic [63:0] b;
    bit          reset_bad;
    clk = 1'b0;
    rst_n = 1'b0;
    dividend = '0;
    divisor = '0;
    div_type = '0;
    div_valid = 1'b0;
    flush = 1'b0;
    seed = 32;
    tests = 0;
    fails = 0;
    pending = 1'b0;
    reset_bad = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b1) begin
      $display("ERR reset out_valid expected 1 actual %b", out_valid);
      reset_bad = 1'b1;
    end
    if (result !== '0) begin
      $display("ERR reset result expected %h actual %h", 64'd0, result);
      reset_bad = 1'b1;
    end
    finish_test("reset", reset_bad);

    // short shifts make divisor > dividend common
    for (int i = 0; i < 8; i++) begin
      a = rand64() >> ($random(seed) & 63);
      b = rand64() >> ($random(seed) & 63);
      if (b == 64'd0) b = 64'd7;
      run_request($sformatf("divu_%0d", i), a, b, div_pkg::op_divu);
      run_request($sformatf("remu_%0d", i), a, b, div_pkg::op_remu);
    end

    // divisor well above the dividend
    run_request("divu_small", 64'd12345, 64'hf000_0000_0000_0001, div_pkg::op_divu);
    run_request("remu_small", 64'd12345, 64'hf000_0000_0000_0001, div_pkg::op_remu);

    // bit 0 of s negates the dividend, bit 1 the divisor
    for (int s = 0; s < 8; s++) begin
      a = rand64() >> (1 + ($random(seed) & 31));
      b = rand64() >> (1 + ($random(seed) & 62));
      if (b == 64'd0) b = 64'd3;
      if (s[0]) a = -a;
      if (s[1]) b = -b;
      run_request($sformatf("div_s%0d", s), a, b, div_pkg::op_div);
      run_request($sformatf("rem_s%0d", s), a, b, div_pkg::op_rem);
    end

    a = rand64();
    run_request("div_by_zero", a, 64'd0, div_pkg::op_div);
    run_request("divu_by_zero", a, 64'd0, div_pkg::op_divu);
    run_request("rem_by_zero", a, 64'd0, div_pkg::op_rem);
    run_request("remu_by_zero", a, 64'd0, div_pkg::op_remu);
    run_request("div_overflow", 64'h8000_0000_0000_0000, '1, div_pkg::op_div);
    run_request("rem_overflow", 64'h8000_0000_0000_0000, '1, div_pkg::op_rem);
    run_request("div_by_one", -rand64(), 64'd1, div_pkg::op_div);
    run_request("divu_by_one", rand64(), 64'd1, div_pkg::op_divu);

    flush_request(rand64(), 64'd12345);
    run_request("after_flush", 64'd1000003, 64'd97, div_pkg::op_remu);

    $display("tests %0d, failed %0d", tests, fails);
    if (fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (planned_ops * 80 + 100) @(posedge clk);
    $display("watchdog: run did not finish in %0d cycles", planned_ops * 80 + 100);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
